//--- hdl/fetchPkg.sv
// ==================================================
// shared sizes, opcodes and stage types for the
// variable-length fetch front end
// every RTL module imports this package by wildcard
// ==================================================
package fetchPkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int PC_W         = 32;
	localparam int INSN_W       = 48;
	localparam int CODE_PARCELS = 512;
	localparam int XTAB_DEPTH   = 64;
	localparam int QUEUE_DEPTH  = 4;

	// derived index widths
	localparam int PARCEL_AW = $clog2(CODE_PARCELS);
	localparam int XTAB_AW   = $clog2(XTAB_DEPTH);
	localparam int QPTR_W    = $clog2(QUEUE_DEPTH);

	// address map and restart point
	localparam logic [PC_W-1:0] RESET_PC  = 32'h0000_0000;
	localparam logic [31:0]     XTAB_BASE = 32'h0000_1000;

	// AXI response code
	localparam logic [1:0] BRESP_OKAY = 2'b00;

	// ==================================================
	// opcodes
	// ==================================================
	// anything not listed here is plain sequential
	localparam logic [5:0] OP_NOP = 6'h00;
	localparam logic [5:0] OP_BR  = 6'h10;
	localparam logic [5:0] OP_JMP = 6'h11;

	// generic register/immediate form
	typedef struct packed {
		logic [24:0] imm;
		logic [4:0]  rb;
		logic [4:0]  ra;
		logic [4:0]  rt;
		logic [1:0]  lenCode;
		logic [5:0]  opcode;
	} insnGen_t;

	// branch/jump form, disp counted in halfwords
	typedef struct packed {
		logic [15:0] spare;
		logic [23:0] disp;
		logic [1:0]  lenCode;
		logic [5:0]  opcode;
	} insnBr_t;

	// lenCode 0 -> 4 bytes, 1 -> 6 bytes, 2/3 -> compressed
	typedef union packed {
		insnGen_t gen;
		insnBr_t  br;
	} insnWord_t;

	// one fetched instruction as it moves down the pipe
	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		insnWord_t       insn;
		logic [2:0]      len;
	} fetchSlot_t;

	// fetch restart request
	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] target;
	} redirect_t;

	// loader bus, write channels only
	typedef struct packed {
		logic [31:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
	} axiLiteW_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;
		logic       bvalid;
	} axiLiteWRsp_t;

endpackage

//--- hdl/codeStore.sv
// ==================================================
// program parcels and compressed expansion table
// written by the loader over AXI4-Lite, read by the
// fetcher through two asynchronous ports
// ==================================================
`timescale 1ns/1ps

module codeStore import fetchPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  axiLiteW_t            axi_i,
	output axiLiteWRsp_t         axi_o,
	input  logic [PC_W-1:0]      rdAddr_i,
	output logic [INSN_W-1:0]    rdWord_o,
	input  logic [XTAB_AW-1:0]   xIdx_i,
	output logic [INSN_W-1:0]    xWord_o
);

	logic [15:0] parcel [CODE_PARCELS];
	logic [31:0] xtab [XTAB_DEPTH];

	logic                 wrAccept;
	logic                 inTable;
	logic                 bValid;
	logic [PARCEL_AW-1:0] wrIdx;
	logic [PARCEL_AW-1:0] wrIdxHi;
	logic [XTAB_AW-1:0]   tabIdx;
	logic [PARCEL_AW-1:0] rdIdx;

	// ==================================================
	// write handshake
	// ==================================================
	// address and data are taken together, one at a time
	assign wrAccept = axi_i.awvalid & axi_i.wvalid & ~bValid;
	assign inTable  = axi_i.awaddr >= XTAB_BASE;
	assign wrIdx    = axi_i.awaddr[PARCEL_AW:1];
	assign wrIdxHi  = wrIdx + PARCEL_AW'(1);
	assign tabIdx   = axi_i.awaddr[XTAB_AW+1:2];

	always_comb
	begin
		axi_o.awready = wrAccept;
		axi_o.wready  = wrAccept;
		axi_o.bresp   = BRESP_OKAY;
		axi_o.bvalid  = bValid;
	end

	// response raised the cycle after accept, held until bready
	always_ff @(posedge clk)
	begin
		if (rst)
			bValid <= 1'b0;
		else if (wrAccept)
			bValid <= 1'b1;
		else if (axi_i.bready)
			bValid <= 1'b0;
	end

	// code word lands as two parcels, low half first
	always_ff @(posedge clk)
	begin
		if (wrAccept && !inTable)
		begin
			if (axi_i.wstrb[0]) parcel[wrIdx][7:0]    <= axi_i.wdata[7:0];
			if (axi_i.wstrb[1]) parcel[wrIdx][15:8]   <= axi_i.wdata[15:8];
			if (axi_i.wstrb[2]) parcel[wrIdxHi][7:0]  <= axi_i.wdata[23:16];
			if (axi_i.wstrb[3]) parcel[wrIdxHi][15:8] <= axi_i.wdata[31:24];
		end
		if (wrAccept && inTable)
		begin
			for (int b = 0; b < 4; b++)
				if (axi_i.wstrb[b])
					xtab[tabIdx][8*b +: 8] <= axi_i.wdata[8*b +: 8];
		end
	end

	// ==================================================
	// fetch read ports
	// ==================================================
	// three parcels from the pc, wrapping at the top
	assign rdIdx    = rdAddr_i[PARCEL_AW:1];
	assign rdWord_o = {parcel[rdIdx + PARCEL_AW'(2)], parcel[rdIdx + PARCEL_AW'(1)],
		parcel[rdIdx]};
	assign xWord_o  = {16'h0000, xtab[xIdx_i]};

	// a pending response must not drop before the loader takes it
	bHold: assert property (@(posedge clk) disable iff (rst)
		bValid && !axi_i.bready |=> bValid)
		else $error("bvalid dropped before bready");

endmodule

//--- hdl/pcFetcher.sv
// ==================================================
// fetch producer, owns the program counter
// decodes length, expands compressed parcels and
// hands one instruction per cycle to the buffer
// ==================================================
`timescale 1ns/1ps

module pcFetcher import fetchPkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                fetchEn_i,
	input  logic                slotFree_i,
	input  redirect_t           redirect_i,
	input  redirect_t           miss_i,
	input  logic [INSN_W-1:0]   rdWord_i,
	input  logic [INSN_W-1:0]   xWord_i,
	output logic [PC_W-1:0]     rdAddr_o,
	output logic [XTAB_AW-1:0]  xIdx_o,
	output fetchSlot_t          slot_o
);

	logic [PC_W-1:0] pc;
	insnWord_t       raw;
	logic            compressed;
	logic            fetchOk;
	logic [2:0]      len;

	// ==================================================
	// decode of the word at the pc
	// ==================================================
	assign rdAddr_o = pc;
	assign raw      = rdWord_i;

	// table index sits right above the first parcel's lenCode
	assign xIdx_o     = rdWord_i[13:8];
	assign compressed = raw.gen.lenCode[1];

	// a slot is only written into a free buffer slot
	// and never on a cycle that restarts fetch
	assign fetchOk = fetchEn_i & slotFree_i & ~redirect_i.valid & ~miss_i.valid;

	always_comb
	begin
		case (raw.gen.lenCode)
			2'd0:    len = 3'd4;
			2'd1:    len = 3'd6;
			default: len = 3'd2;
		endcase
	end

	always_comb
	begin
		slot_o.valid = fetchOk;
		slot_o.pc    = pc;
		slot_o.len   = len;
		// compressed parcel is replaced by its table entry
		if (compressed)
			slot_o.insn = xWord_i;
		else
			slot_o.insn = raw;
	end

	// ==================================================
	// pc update
	// ==================================================
	// miss over redirect over sequential advance
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= RESET_PC;
		else if (miss_i.valid)
			pc <= miss_i.target;
		else if (redirect_i.valid)
			pc <= redirect_i.target;
		else if (fetchOk)
			pc <= pc + PC_W'(len);
	end

endmodule

//--- hdl/fetchBuffer.sv
// ==================================================
// two-slot ping-pong fetch buffer
// presents the older slot as head, resolves jumps and
// statically predicted branches, redirects the fetcher
// ==================================================
`timescale 1ns/1ps

module fetchBuffer import fetchPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  fetchSlot_t slot_i,
	input  redirect_t  miss_i,
	output logic       slotFree_o,
	output fetchSlot_t head_o,
	input  logic       headReady_i,
	output redirect_t  redirect_o
);

	fetchSlot_t      slotA;
	fetchSlot_t      slotB;
	// 0 selects A as head, 1 selects B
	logic            steer;
	fetchSlot_t      head;
	logic            headTake;
	logic            isJmp;
	logic            isTakenBr;
	logic [PC_W-1:0] dispOff;
	logic [PC_W-1:0] jmpTarget;

	// ==================================================
	// head select and static prediction
	// ==================================================
	assign head       = steer ? slotB : slotA;
	assign head_o     = head;
	assign headTake   = head.valid & headReady_i;
	assign slotFree_o = ~slotA.valid | ~slotB.valid;

	// backward displacement predicts taken
	assign isJmp     = head.insn.br.opcode == OP_JMP;
	assign isTakenBr = (head.insn.br.opcode == OP_BR) & head.insn.br.disp[23];

	// halfword displacement to bytes, signed for branches
	assign dispOff   = {{(PC_W-25){head.insn.br.disp[23]}}, head.insn.br.disp, 1'b0};
	// jump target is absolute
	assign jmpTarget = {{(PC_W-25){1'b0}}, head.insn.br.disp, 1'b0};

	always_comb
	begin
		redirect_o.valid  = headTake & (isJmp | isTakenBr);
		redirect_o.target = isJmp ? jmpTarget : head.pc + dispOff;
	end

	// ==================================================
	// slot state
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (rst || miss_i.valid)
		begin
			slotA.valid <= 1'b0;
			slotB.valid <= 1'b0;
			steer       <= 1'b0;
		end
		else if (redirect_o.valid)
		begin
			// head goes to the queue, the wrong-path slot is dropped
			slotA.valid <= 1'b0;
			slotB.valid <= 1'b0;
			steer       <= 1'b0;
		end
		else
		begin
			if (headTake)
			begin
				if (steer)
					slotB.valid <= 1'b0;
				else
					slotA.valid <= 1'b0;
				steer <= ~steer;
			end
			// both empty, next fill goes to A which becomes head
			if (!slotA.valid && !slotB.valid)
				steer <= 1'b0;
			// fill whichever slot is free, A first
			if (slot_i.valid)
			begin
				if (!slotA.valid)
					slotA <= slot_i;
				else
					slotB <= slot_i;
			end
		end
	end

	// head must point at the older valid slot
	steerOk: assert property (@(posedge clk) disable iff (rst)
		!(!head.valid && (steer ? slotA.valid : slotB.valid)))
		else $error("steering selects an empty slot while the other is full");

	// the fetcher only writes into a free slot and never during a redirect
	fillOk: assert property (@(posedge clk) disable iff (rst)
		slot_i.valid |-> slotFree_o && !redirect_o.valid)
		else $error("fetcher wrote with no free slot or during redirect");

endmodule

//--- hdl/issueQueue.sv
// ==================================================
// issue queue, small circular FIFO of fetched slots
// presented on a valid/ready output, emptied by a miss
// ==================================================
`timescale 1ns/1ps

module issueQueue import fetchPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  fetchSlot_t in_i,
	output logic       notFull_o,
	input  redirect_t  miss_i,
	output fetchSlot_t out_o,
	input  logic       outReady_i
);

	fetchSlot_t        mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wrPtr;
	logic [QPTR_W-1:0] rdPtr;
	logic [QPTR_W:0]   count;
	logic              push;
	logic              pop;

	assign notFull_o = count != (QPTR_W+1)'(QUEUE_DEPTH);
	assign push      = in_i.valid & notFull_o;
	assign pop       = out_o.valid & outReady_i;

	always_comb
	begin
		out_o       = mem[rdPtr];
		out_o.valid = count != '0;
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= in_i;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk)
	begin
		if (rst || miss_i.valid)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop)  rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// a refused head stays put in the buffer until pushed
	inHold: assert property (@(posedge clk) disable iff (rst)
		in_i.valid && !notFull_o && !miss_i.valid |=> in_i.valid && $stable(in_i))
		else $error("buffer head changed while the queue was full");

	outHold: assert property (@(posedge clk) disable iff (rst)
		out_o.valid && !outReady_i && !miss_i.valid |=> out_o.valid && $stable(out_o))
		else $error("output changed while stalled");

endmodule

//--- hdl/fetchTop.sv
// ==================================================
// fetch front end top level
// loader port, fetcher, ping-pong buffer, issue queue
// ==================================================
`timescale 1ns/1ps

module fetchTop import fetchPkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  axiLiteW_t    axi_i,
	output axiLiteWRsp_t axi_o,
	input  logic         fetchEn_i,
	input  redirect_t    miss_i,
	output fetchSlot_t   out_o,
	input  logic         outReady_i
);

	// code store read ports
	logic [PC_W-1:0]    rdAddr;
	logic [INSN_W-1:0]  rdWord;
	logic [XTAB_AW-1:0] xIdx;
	logic [INSN_W-1:0]  xWord;

	// fetcher to buffer
	logic               slotFree;
	fetchSlot_t         fetchSlot;
	redirect_t          redirect;

	// buffer to queue
	fetchSlot_t         head;
	logic               notFull;

	codeStore store0 (.clk(clk), .rst(rst), .axi_i(axi_i), .axi_o(axi_o),
		.rdAddr_i(rdAddr), .rdWord_o(rdWord), .xIdx_i(xIdx), .xWord_o(xWord));

	pcFetcher fetch0 (.clk(clk), .rst(rst), .fetchEn_i(fetchEn_i),
		.slotFree_i(slotFree), .redirect_i(redirect), .miss_i(miss_i),
		.rdWord_i(rdWord), .xWord_i(xWord), .rdAddr_o(rdAddr), .xIdx_o(xIdx),
		.slot_o(fetchSlot));

	fetchBuffer buf0 (.clk(clk), .rst(rst), .slot_i(fetchSlot), .miss_i(miss_i),
		.slotFree_o(slotFree), .head_o(head), .headReady_i(notFull),
		.redirect_o(redirect));

	issueQueue queue0 (.clk(clk), .rst(rst), .in_i(head), .notFull_o(notFull),
		.miss_i(miss_i), .out_o(out_o), .outReady_i(outReady_i));

endmodule

//--- verif/fetchTb.sv
// ==================================================
// testbench for the fetch front end
// loads the code store from the stimulus file, runs the
// program under random back-pressure, then a miss restart
// ==================================================
`timescale 1ns/1ps

module fetchTb import fetchPkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int RST_CYCLES  = 5;
	localparam int STIM_DEPTH  = 64;
	localparam int HOLD_CYCLES = 8;

	// record kinds in the stimulus file
	localparam logic [3:0] REC_WRITE    = 4'h1;
	localparam logic [3:0] REC_EXP      = 4'h2;
	localparam logic [3:0] REC_MISS     = 4'h3;
	localparam logic [3:0] REC_EXP_MISS = 4'h4;

	logic         clk;
	logic         rst;
	axiLiteW_t    axiIn;
	axiLiteWRsp_t axiOut;
	logic         fetchEn;
	redirect_t    miss;
	fetchSlot_t   outSlot;
	logic         outReady;

	// kind, pc or address, insn or data, len
	logic [87:0]     stim [STIM_DEPTH];
	logic [31:0]     wrAddr [STIM_DEPTH];
	logic [31:0]     wrData [STIM_DEPTH];
	fetchSlot_t      expMain [STIM_DEPTH];
	fetchSlot_t      expMiss [STIM_DEPTH];
	logic [PC_W-1:0] missTarget;
	int              nWrites;
	int              nMain;
	int              nMiss;
	logic [31:0]     rndState;
	int              limitCycles = 0;
	int              errCount;
	int              checkCount;
	int              testCount;

	fetchTop dut0 (.clk(clk), .rst(rst), .axi_i(axiIn), .axi_o(axiOut), .fetchEn_i(fetchEn),
		.miss_i(miss), .out_o(outSlot), .outReady_i(outReady));

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// where fetch goes after an instruction, jump absolute,
	// backward branch taken, everything else falls through
	function automatic logic [PC_W-1:0] followPc(input fetchSlot_t s);
		int dispBytes;
		dispBytes = 2 * $signed(s.insn.br.disp);
		if (s.insn.br.opcode == OP_JMP)
			return PC_W'(s.insn.br.disp) * 2;
		else if (s.insn.br.opcode == OP_BR && dispBytes < 0)
			return s.pc + PC_W'(dispBytes);
		else
			return s.pc + PC_W'(s.len);
	endfunction

	function automatic string slotText(input fetchSlot_t s);
		return $sformatf("pc %h insn %h len %0d valid %b", s.pc, s.insn, s.len, s.valid);
	endfunction

	function automatic string respText(input axiLiteWRsp_t r);
		return $sformatf("awready %b wready %b bresp %h bvalid %b", r.awready, r.wready,
			r.bresp, r.bvalid);
	endfunction

	task automatic checkSlot(input string name, input fetchSlot_t got, input fetchSlot_t exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("Error at %0d ns: %s = %s, expected %s", $time, name, slotText(got),
				slotText(exp));
		end
	endtask

	task automatic checkResp(input string name, input axiLiteWRsp_t got,
		input axiLiteWRsp_t exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("Error at %0d ns: %s = %s, expected %s", $time, name, respText(got),
				respText(exp));
		end
	endtask

	task automatic checkPc(input string name, input logic [PC_W-1:0] got,
		input logic [PC_W-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errStart, input int checkStart);
		testCount++;
		$display("test %0d %s: %0d checks, %0d errors", testCount, name,
			checkCount - checkStart, errCount - errStart);
	endtask

	// unread lines stay all ones and read as end records
	task automatic loadStimulus();
		logic [3:0] kind;
		for (int i = 0; i < STIM_DEPTH; i++)
			stim[i] = '1;
		$readmemh("verif/fetchStimulus.mem", stim);
		nWrites = 0;
		nMain   = 0;
		nMiss   = 0;
		for (int i = 0; i < STIM_DEPTH; i++)
		begin
			kind = stim[i][87:84];
			if (kind == REC_WRITE)
			begin
				wrAddr[nWrites] = stim[i][83:52];
				wrData[nWrites] = stim[i][35:4];
				nWrites++;
			end
			else if (kind == REC_MISS)
				missTarget = stim[i][83:52];
			else if (kind == REC_EXP || kind == REC_EXP_MISS)
			begin
				if (kind == REC_EXP)
				begin
					expMain[nMain] = {1'b1, stim[i][83:52], stim[i][51:4], stim[i][2:0]};
					nMain++;
				end
				else
				begin
					expMiss[nMiss] = {1'b1, stim[i][83:52], stim[i][51:4], stim[i][2:0]};
					nMiss++;
				end
			end
		end
	endtask

	// ==================================================
	// bus and stream drivers
	// ==================================================
	task automatic loaderWrite(input logic [31:0] addr, input logic [31:0] data);
		axiLiteWRsp_t okRsp;
		okRsp.awready = 1'b0;
		okRsp.wready  = 1'b0;
		okRsp.bresp   = BRESP_OKAY;
		okRsp.bvalid  = 1'b1;
		@(negedge clk);
		axiIn.awaddr  = addr;
		axiIn.wdata   = data;
		axiIn.wstrb   = 4'hf;
		axiIn.awvalid = 1'b1;
		axiIn.wvalid  = 1'b1;
		axiIn.bready  = 1'b1;
		// ready settles in the low phase and holds to the edge
		#(CLK_PERIOD/4);
		while (!(axiOut.awready && axiOut.wready))
		begin
			@(negedge clk);
			#(CLK_PERIOD/4);
		end
		@(negedge clk);
		axiIn.awvalid = 1'b0;
		axiIn.wvalid  = 1'b0;
		#(CLK_PERIOD/4);
		// response pending the cycle after accept
		checkResp("axi_o", axiOut, okRsp);
	endtask

	// random ready per cycle, each transfer checked in order
	task automatic collectStream(input bit afterMiss);
		fetchSlot_t expSlot;
		fetchSlot_t prevSlot;
		int         got;
		int         total;
		logic       ready;
		got   = 0;
		total = afterMiss ? nMiss : nMain;
		while (got < total)
		begin
			@(negedge clk);
			rndState = xorshift(rndState);
			ready    = |rndState[1:0];
			outReady = ready;
			#(CLK_PERIOD/4);
			if (outSlot.valid && ready)
			begin
				expSlot = afterMiss ? expMiss[got] : expMain[got];
				checkSlot("out_o", outSlot, expSlot);
				if (afterMiss && got == 0)
					checkPc("out_o.pc after miss", outSlot.pc, missTarget);
				if (got > 0)
					checkPc("out_o.pc after previous", outSlot.pc, followPc(prevSlot));
				// next pc follows from the expected instruction
				prevSlot = expSlot;
				got++;
			end
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		int errStart;
		int checkStart;
		rst        = 1'b1;
		axiIn      = '0;
		fetchEn    = 1'b0;
		miss       = '0;
		outReady   = 1'b0;
		errCount   = 0;
		checkCount = 0;
		testCount  = 0;
		rndState   = 32'h7bd5_1940;
		loadStimulus();
		limitCycles = nWrites + (nMain + nMiss) * 4 + 50;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		errStart   = errCount;
		checkStart = checkCount;
		for (int i = 0; i < nWrites; i++)
			loaderWrite(wrAddr[i], wrData[i]);
		reportTest("loader writes", errStart, checkStart);

		// straight line, compressed, jump and branches, random stalls
		errStart   = errCount;
		checkStart = checkCount;
		@(negedge clk);
		fetchEn = 1'b1;
		collectStream(1'b0);
		reportTest("program stream", errStart, checkStart);

		// fill the queue, then flush and restart
		errStart   = errCount;
		checkStart = checkCount;
		@(negedge clk);
		outReady = 1'b0;
		repeat (HOLD_CYCLES) @(negedge clk);
		miss.valid  = 1'b1;
		miss.target = missTarget;
		@(negedge clk);
		miss = '0;
		#(CLK_PERIOD/4);
		checkCount++;
		if (outSlot.valid !== 1'b0)
		begin
			errCount++;
			$display("Error at %0d ns: out_o.valid = %b, expected 0 right after the miss",
				$time, outSlot.valid);
		end
		collectStream(1'b1);
		reportTest("miss restart", errStart, checkStart);

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// run length bound from the number of records
	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limitCycles);
		$display("Test failed");
		$finish;
	end

endmodule

//--- verif/fetchStimulus.mem
// columns: kind _ address or pc _ data or insn (48 bits) _ len
// kind 1 loader write, 2 expected output, 3 miss target, 4 expected after miss, f end
1_00000000_0000A1B2C301_0
1_00000004_0000F00D1241_0
1_00000008_000003820BAD_0
1_0000000C_000000002010_0
1_00000010_000000001011_0
1_00000014_0000DEAD0001_0
1_00000018_0000DEAD0001_0
1_00000020_000077771101_0
1_00000024_000044445541_0
1_00000028_0000FB103333_0
1_0000002C_00000000FFFF_0
1_00000030_000000000000_0
1_00000040_000044440003_0
1_00000044_0000234105C3_0
1_00000048_0000ABCDEF01_0
1_0000004C_000000002011_0
1_00000050_000000000000_0
1_00000054_000000000000_0
1_0000100C_0000CAFE0005_0
1_00001014_000013579BDF_0
2_00000000_1241A1B2C301_4
2_00000004_0BADF00D1241_6
2_0000000A_0000CAFE0005_2
2_0000000C_101100002010_4
2_00000010_000100001011_4
2_00000020_554177771101_4
2_00000024_333344445541_6
2_0000002A_0000FFFFFB10_4
2_00000020_554177771101_4
2_00000024_333344445541_6
2_0000002A_0000FFFFFB10_4
3_00000040_000000000000_0
4_00000040_05C344440003_4
4_00000044_000013579BDF_2
4_00000046_ABCDEF012341_6
4_0000004C_000000002011_4
4_00000040_05C344440003_4
F_00000000_000000000000_0

//--- sim.f
hdl/fetchPkg.sv
hdl/codeStore.sv
hdl/pcFetcher.sv
hdl/fetchBuffer.sv
hdl/issueQueue.sv
hdl/fetchTop.sv
verif/fetchTb.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - hdl/fetchPkg.sv
  - hdl/codeStore.sv
  - hdl/pcFetcher.sv
  - hdl/fetchBuffer.sv
  - hdl/issueQueue.sv
  - hdl/fetchTop.sv
  - target: test
    files:
      - verif/fetchTb.sv
